// ==== build.f ====
+incdir+.
icache_types_pkg.sv
icache_mem_pkg.sv
way_ram.sv
plru_victim.sv
lookup_stage.sv
hit_stage.sv
refill_ctrl.sv
icache_top.sv
tb_mem_model.sv
tb_icache.sv

// ==== run.sh ====
#!/bin/sh
# build and run the icache testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_icache -o sim_icache
status=$?
if [ $status -ne 0 ]; then
    echo "verilator build failed with status $status"
    exit 1
fi

sim_out=$(./obj_dir/sim_icache 2>&1)
status=$?
printf '%s\n' "$sim_out"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$sim_out" | grep -q "TEST RESULT: PASS"; then
    exit 0
else
    echo "pass line not found in simulation output"
    exit 1
fi

// ==== tb_icache.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module tb_icache;

    import icache_types_pkg::*;
    import icache_mem_pkg::*;

    // sweep of 129 cycles, about ten refills of ~20 cycles and a few hits
    localparam int CYCLE_LIMIT = 4000;
    localparam int SWEEP_LEN   = `ICACHE_SWEEP_CYCLES + 1;

    typedef struct packed {
        cpu_req_t req;
        logic     hit;
        int       cycle;
    } pending_t;

    logic         clk;
    logic         rst;
    cpu_req_t     req;
    logic         req_valid;
    logic         index_ok;
    logic         data_ok;
    half_line_t   rdata;
    mem_rd_req_t  rd_req;
    logic         rd_ready;
    mem_rd_resp_t rd_resp;

    int cycle       = 0;
    int since_reset = 0;
    int refills     = 0;
    int last_done   = 0;
    int accept_wait = 0;

    // reference model state
    tag_entry_t  shadow [`ICACHE_SETS][`ICACHE_WAYS];
    logic [2:0]  tree [`ICACHE_SETS];
    pending_t    pend [$];
    logic [31:0] refill_addr [$];

    icache_top u_dut (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .req_valid (req_valid),
        .index_ok  (index_ok),
        .data_ok   (data_ok),
        .rdata     (rdata),
        .rd_req    (rd_req),
        .rd_ready  (rd_ready),
        .rd_resp   (rd_resp)
    );

    tb_mem_model #(.SEED(6767)) u_mem (
        .clk      (clk),
        .rst      (rst),
        .rd_req   (rd_req),
        .rd_ready (rd_ready),
        .rd_resp  (rd_resp)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("TEST RESULT: FAIL");
        $fatal(1, "testbench stopped");
    endtask

    task automatic show_mismatch(input string name, input logic [127:0] expected,
                                 input logic [127:0] actual);
        abort_run($sformatf("ERR t=%0t %s expected %h actual %h", $time, name,
                            expected, actual));
    endtask

    // four memory words of the requested half
    function automatic half_line_t mem_half(input cpu_req_t r);
        half_line_t  h;
        logic [29:0] w;
        for (int i = 0; i < 4; i++) begin
            w = {r.tag, r.index, r.half, 2'(i)};
            h[i*32 +: 32] = {2'b00, w} ^ 32'h5a5a_0000;
        end
        return h;
    endfunction

    function automatic int plru_pick(input logic [2:0] t);
        if (!t[0]) begin
            return t[1] ? 1 : 0;
        end
        return t[2] ? 3 : 2;
    endfunction

    function automatic logic [2:0] plru_touch(input logic [2:0] t, input int way);
        case (way)
            0:       return {t[2], 1'b1, 1'b1};
            1:       return {t[2], 1'b0, 1'b1};
            2:       return {1'b1, t[1], 1'b0};
            default: return {1'b0, t[1], 1'b0};
        endcase
    endfunction

    // returns hit; on a miss installs the line and queues the burst address
    function automatic logic model_fetch(input cpu_req_t r);
        int way;
        way = -1;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            if (shadow[r.index][w].valid && shadow[r.index][w].tag == r.tag) begin
                way = w;
            end
        end
        if (way >= 0) begin
            return 1'b1;
        end
        way = plru_pick(tree[r.index]);
        tree[r.index] = plru_touch(tree[r.index], way);
        shadow[r.index][way] = '{valid: 1'b1, tag: r.tag};
        // line base address plus 16 bytes for the upper half
        refill_addr.push_back({r.tag, r.index, 5'b00000} + (r.half ? 32'h10 : 32'h0));
        return 1'b0;
    endfunction

    ////////////////////////////////////////////////////////////
    // monitor and checks

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= CYCLE_LIMIT) begin
            abort_run($sformatf("timeout: run not finished after %0d cycles", CYCLE_LIMIT));
        end
    end

    always @(posedge clk) begin
        pending_t    done;
        logic        hit_now;
        logic [31:0] exp_addr;
        if (!rst) begin
            since_reset = 0;
            pend.delete();
            refill_addr.delete();
            for (int s = 0; s < `ICACHE_SETS; s++) begin
                tree[s] = 3'b000;
                for (int w = 0; w < `ICACHE_WAYS; w++) begin
                    shadow[s][w] = '0;
                end
            end
        end else begin
            if (since_reset < SWEEP_LEN) begin
                assert (!index_ok) else show_mismatch("index_ok", 128'd0, 128'(index_ok));
                assert (!rd_req.valid)
                    else show_mismatch("rd_req.valid", 128'd0, 128'(rd_req.valid));
            end
            if (since_reset == SWEEP_LEN && req_valid) begin
                assert (index_ok) else show_mismatch("index_ok", 128'd1, 128'(index_ok));
            end
            if (req_valid && index_ok) begin
                hit_now = model_fetch(req);
                pend.push_back('{req: req, hit: hit_now, cycle: cycle});
            end
            if (rd_req.valid && rd_ready) begin
                refills++;
                assert (refill_addr.size() != 0)
                    else abort_run("rd_req issued for a request that should hit");
                exp_addr = refill_addr.pop_front();
                assert (rd_req.addr == exp_addr)
                    else show_mismatch("rd_req.addr", 128'(exp_addr), 128'(rd_req.addr));
            end
            if (data_ok) begin
                assert (pend.size() != 0) else abort_run("data_ok with no request outstanding");
                done = pend.pop_front();
                assert (rdata == mem_half(done.req))
                    else show_mismatch("rdata", mem_half(done.req), rdata);
                // unstalled hit
                if (done.hit && last_done <= done.cycle + 1) begin
                    assert (cycle - done.cycle == 2)
                        else show_mismatch("data_ok latency", 128'd2, 128'(cycle - done.cycle));
                end
                last_done = cycle;
            end
            since_reset++;
        end
    end

    ////////////////////////////////////////////////////////////
    // stimulus

    task automatic send_req(input tag_t tag, input set_idx_t index, input half_t half);
        @(negedge clk);
        req         = '{tag: tag, index: index, half: half};
        req_valid   = 1'b1;
        accept_wait = 0;
        @(posedge clk);
        while (!index_ok) begin
            accept_wait++;
            @(posedge clk);
        end
    endtask

    task automatic wait_idle;
        @(negedge clk);
        req_valid = 1'b0;
        while (pend.size() != 0) @(negedge clk);
    endtask

    task automatic expect_refills(input int count);
        assert (refills == count)
            else show_mismatch("refill count", 128'(count), 128'(refills));
    endtask

    task automatic expect_no_wait;
        assert (accept_wait == 0)
            else show_mismatch("index_ok wait cycles", 128'd0, 128'(accept_wait));
    endtask

    initial begin
        rst       = 1'b0;
        req       = '0;
        req_valid = 1'b0;
        repeat (4) @(negedge clk);
        rst = 1'b1;

        // request held through the sweep before a cold miss
        send_req(20'h00012, 7'd5, 1'b0);
        wait_idle();
        expect_refills(1);

        // upper half first in the burst
        send_req(20'h00034, 7'd9, 1'b1);
        wait_idle();
        expect_refills(2);

        // resident lines back to back
        for (int i = 0; i < 4; i++) begin
            send_req(20'h00012, 7'd5, i[0]);
            if (i > 0) begin
                expect_no_wait();
            end
            send_req(20'h00034, 7'd9, i[0]);
            expect_no_wait();
        end
        wait_idle();
        expect_refills(2);

        // second half queued behind its own miss
        send_req(20'h00056, 7'd9, 1'b1);
        send_req(20'h00056, 7'd9, 1'b0);
        wait_idle();
        expect_refills(3);

        // five tags into one set
        for (int i = 0; i < 5; i++) begin
            send_req(tag_t'(32'h100 + i), 7'd20, 1'b0);
        end
        wait_idle();
        expect_refills(8);
        for (int i = 1; i < 4; i++) begin
            send_req(tag_t'(32'h100 + i), 7'd20, i[0]);
        end
        wait_idle();
        expect_refills(8);
        send_req(20'h00100, 7'd20, 1'b1);
        wait_idle();
        expect_refills(9);

        assert (refill_addr.size() == 0) else abort_run("predicted refill was never issued");
        $display("TEST RESULT: PASS");
        $finish;
    end

endmodule

// ==== tb_mem_model.sv ====
`timescale 1ns/1ps

module tb_mem_model #(
    parameter int unsigned SEED = 1
) (
    input  logic                         clk,
    input  logic                         rst,
    input  icache_mem_pkg::mem_rd_req_t  rd_req,
    output logic                         rd_ready,
    output icache_mem_pkg::mem_rd_resp_t rd_resp
);

    import icache_mem_pkg::*;

    // one burst at a time, word A returns A ^ 5a5a0000
    initial begin
        int unsigned wait_cycles;
        logic [29:0] word_addr;
        logic [29:0] beat_addr;
        rd_ready = 1'b0;
        rd_resp  = '0;
        void'($urandom(SEED));
        forever begin
            @(negedge clk);
            if (rst && rd_req.valid) begin
                wait_cycles = $urandom_range(3, 0);
                repeat (wait_cycles) @(negedge clk);
                word_addr = rd_req.addr[31:2];
                rd_ready  = 1'b1;
                @(negedge clk);
                rd_ready = 1'b0;
                // wrap inside the line, starting at the requested word
                for (int i = 0; i < 8; i++) begin
                    beat_addr     = {word_addr[29:3], word_addr[2:0] + 3'(i)};
                    rd_resp.valid = 1'b1;
                    rd_resp.data  = {2'b00, beat_addr} ^ 32'h5a5a_0000;
                    rd_resp.last  = (i == 7);
                    @(negedge clk);
                end
                rd_resp = '0;
            end
        end
    end

endmodule

// ==== icache_top.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module icache_top (
    input  logic                          clk,
    input  logic                          rst,
    input  icache_types_pkg::cpu_req_t    req,
    input  logic                          req_valid,
    output logic                          index_ok,
    output logic                          data_ok,
    output icache_types_pkg::half_line_t  rdata,
    output icache_mem_pkg::mem_rd_req_t   rd_req,
    input  logic                          rd_ready,
    input  icache_mem_pkg::mem_rd_resp_t  rd_resp
);

    import icache_types_pkg::*;
    import icache_mem_pkg::*;

    logic                          advance;
    logic                          run;
    logic                          reload;
    rd_sel_t                       rd_sel;
    set_idx_t                      held_hit_idx;
    array_wr_t                     wr;
    fill_view_t                    fill;
    cpu_req_t                      look_req;
    logic                          look_valid;
    tag_entry_t [`ICACHE_WAYS-1:0] tags;
    line_t [`ICACHE_WAYS-1:0]      lines;
    logic                          miss;
    cpu_req_t                      miss_req;
    way_mask_t                     victim;
    logic                          update;

    ////////////////////////////////////////////////////////////
    // read pipeline

    lookup_stage u_lookup (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .req_valid    (req_valid),
        .index_ok     (index_ok),
        .advance      (advance),
        .run          (run),
        .rd_sel       (rd_sel),
        .held_hit_idx (held_hit_idx),
        .wr           (wr),
        .look_req     (look_req),
        .look_valid   (look_valid),
        .tags         (tags),
        .lines        (lines)
    );

    hit_stage u_hit (
        .clk        (clk),
        .rst        (rst),
        .look_req   (look_req),
        .look_valid (look_valid),
        .tags       (tags),
        .lines      (lines),
        .run        (run),
        .reload     (reload),
        .fill       (fill),
        .advance    (advance),
        .miss       (miss),
        .miss_req   (miss_req),
        .data_ok    (data_ok),
        .rdata      (rdata)
    );

    ////////////////////////////////////////////////////////////
    // miss handling

    refill_ctrl u_refill (
        .clk          (clk),
        .rst          (rst),
        .miss         (miss),
        .miss_req     (miss_req),
        .victim       (victim),
        .rd_req       (rd_req),
        .rd_ready     (rd_ready),
        .rd_resp      (rd_resp),
        .run          (run),
        .reload       (reload),
        .rd_sel       (rd_sel),
        .held_hit_idx (held_hit_idx),
        .wr           (wr),
        .fill         (fill),
        .update       (update)
    );

    plru_victim u_plru (
        .clk    (clk),
        .rst    (rst),
        .miss   (miss),
        .set    (miss_req.index),
        .update (update),
        .victim (victim)
    );

endmodule

// ==== refill_ctrl.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module refill_ctrl (
    input  logic                          clk,
    input  logic                          rst,
    input  logic                          miss,
    input  icache_types_pkg::cpu_req_t    miss_req,
    input  icache_types_pkg::way_mask_t   victim,
    output icache_mem_pkg::mem_rd_req_t   rd_req,
    input  logic                          rd_ready,
    input  icache_mem_pkg::mem_rd_resp_t  rd_resp,
    output logic                          run,
    output logic                          reload,
    output icache_types_pkg::rd_sel_t     rd_sel,
    output icache_types_pkg::set_idx_t    held_hit_idx,
    output icache_mem_pkg::array_wr_t     wr,
    output icache_mem_pkg::fill_view_t    fill,
    output logic                          update
);

    import icache_types_pkg::*;

    localparam int WORD_W = $clog2(`ICACHE_LINE_WORDS);

    cache_state_t      state;
    set_idx_t          sweep_cnt;
    tag_t              fill_tag;
    set_idx_t          fill_idx;
    half_t             fill_half;
    logic [WORD_W-1:0] word_cnt;
    line_t             buf_line;
    logic [1:0]        half_done;

    ////////////////////////////////////////////////////////////
    // controller FSM

    always_ff @(posedge clk) begin
        if (!rst) begin
            state     <= SWEEP;
            sweep_cnt <= '0;
        end else begin
            case (state)
                SWEEP: begin
                    sweep_cnt <= sweep_cnt + 1'b1;
                    if (sweep_cnt == set_idx_t'(`ICACHE_SWEEP_CYCLES - 1)) begin
                        state <= SETTLE;
                    end
                end
                SETTLE:  state <= RUN;
                RUN:     state <= miss ? MISS : RUN;
                MISS:    state <= rd_ready ? REFILL : MISS;
                REFILL:  state <= (rd_resp.valid && rd_resp.last) ? FINISH : REFILL;
                FINISH:  state <= RECOVER;
                RECOVER: state <= SETTLE;
                default: state <= SETTLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == RUN && miss) begin
            fill_tag  <= miss_req.tag;
            fill_idx  <= miss_req.index;
            fill_half <= miss_req.half;
        end
    end

    // wrapping burst, requested half first
    always_ff @(posedge clk) begin
        if (!rst) begin
            word_cnt  <= '0;
            half_done <= 2'b00;
        end else if (state == RUN && miss) begin
            word_cnt <= {miss_req.half, 2'b00};
        end else if (state == REFILL && rd_resp.valid) begin
            word_cnt <= word_cnt + 1'b1;
            if (&word_cnt[1:0]) begin
                half_done[word_cnt[WORD_W-1]] <= 1'b1;
            end
        end else if (state == FINISH) begin
            half_done <= 2'b00;
        end
    end

    always_ff @(posedge clk) begin
        if (state == REFILL && rd_resp.valid) begin
            buf_line[word_cnt*32 +: 32] <= rd_resp.data;
        end
    end

    assign rd_req.valid = (state == MISS);
    assign rd_req.addr  = {fill_tag, fill_idx, fill_half, 4'b0000};
    assign update       = (state == MISS) && rd_ready;

    assign run          = (state == RUN);
    assign reload       = (state == SETTLE);
    assign held_hit_idx = miss_req.index;
    assign rd_sel       = (state == RUN) ? NEW : (state == RECOVER) ? HELD_HIT : HELD_LOOKUP;

    always_comb begin
        wr           = '0;
        wr.entry.tag = fill_tag;
        wr.line      = buf_line;
        if (state == SWEEP) begin
            wr.tag_we = '1;
            wr.index  = sweep_cnt;
        end else if (state == FINISH) begin
            wr.tag_we      = victim;
            wr.data_we     = victim;
            wr.index       = fill_idx;
            wr.entry.valid = 1'b1;
        end
    end

    assign fill.index     = fill_idx;
    assign fill.tag       = fill_tag;
    assign fill.half_done = half_done;
    assign fill.line      = buf_line;

endmodule

// ==== hit_stage.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module hit_stage (
    input  logic                                            clk,
    input  logic                                            rst,
    input  icache_types_pkg::cpu_req_t                      look_req,
    input  logic                                            look_valid,
    input  icache_types_pkg::tag_entry_t [`ICACHE_WAYS-1:0] tags,
    input  icache_types_pkg::line_t [`ICACHE_WAYS-1:0]      lines,
    input  logic                                            run,
    input  logic                                            reload,
    input  icache_mem_pkg::fill_view_t                      fill,
    output logic                                            advance,
    output logic                                            miss,
    output icache_types_pkg::cpu_req_t                      miss_req,
    output logic                                            data_ok,
    output icache_types_pkg::half_line_t                    rdata
);

    import icache_types_pkg::*;

    localparam int HALF_W = $bits(half_line_t);

    logic                            hit_valid;
    cpu_req_t                        hit_req;
    tag_entry_t [`ICACHE_WAYS-1:0]   hit_tags;
    line_t [`ICACHE_WAYS-1:0]        hit_lines;
    way_mask_t                       way_hit;
    half_line_t                      way_data;
    half_line_t                      fill_data;
    logic                            fill_hit;

    always_ff @(posedge clk) begin
        if (!rst) begin
            hit_valid <= 1'b0;
        end else if (advance) begin
            hit_valid <= look_valid;
        end
    end

    // array outputs re-read after a refill
    always_ff @(posedge clk) begin
        if (advance) begin
            hit_req   <= look_req;
            hit_tags  <= tags;
            hit_lines <= lines;
        end else if (reload) begin
            hit_tags  <= tags;
            hit_lines <= lines;
        end
    end

    ////////////////////////////////////////////////////////////
    // tag compare and half-line select

    always_comb begin
        way_data = '0;
        for (int w = 0; w < `ICACHE_WAYS; w++) begin
            way_hit[w] = run && hit_tags[w].valid && (hit_tags[w].tag == hit_req.tag);
            if (way_hit[w]) begin
                way_data = way_data | hit_lines[w][hit_req.half*HALF_W +: HALF_W];
            end
        end
    end

    // served from the line still filling
    assign fill_hit = (fill.index == hit_req.index) && (fill.tag == hit_req.tag)
                      && fill.half_done[hit_req.half];
    assign fill_data = fill.line[hit_req.half*HALF_W +: HALF_W];

    assign data_ok  = hit_valid && ((|way_hit) || fill_hit);
    assign miss     = hit_valid && run && !(|way_hit) && !fill_hit;
    assign advance  = !hit_valid || data_ok;
    assign miss_req = hit_req;
    assign rdata    = fill_hit ? fill_data : way_data;

endmodule

// ==== lookup_stage.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module lookup_stage (
    input  logic                                            clk,
    input  logic                                            rst,
    input  icache_types_pkg::cpu_req_t                      req,
    input  logic                                            req_valid,
    output logic                                            index_ok,
    input  logic                                            advance,
    input  logic                                            run,
    input  icache_types_pkg::rd_sel_t                       rd_sel,
    input  icache_types_pkg::set_idx_t                      held_hit_idx,
    input  icache_mem_pkg::array_wr_t                       wr,
    output icache_types_pkg::cpu_req_t                      look_req,
    output logic                                            look_valid,
    output icache_types_pkg::tag_entry_t [`ICACHE_WAYS-1:0] tags,
    output icache_types_pkg::line_t [`ICACHE_WAYS-1:0]      lines
);

    import icache_types_pkg::*;

    set_idx_t arr_idx;
    logic     wr_any;

    assign index_ok = run && advance;

    always_ff @(posedge clk) begin
        if (!rst) begin
            look_valid <= 1'b0;
        end else if (advance) begin
            look_valid <= index_ok && req_valid;
        end
    end

    always_ff @(posedge clk) begin
        if (index_ok && req_valid) begin
            look_req <= req;
        end
    end

    ////////////////////////////////////////////////////////////
    // array index

    assign wr_any = (|wr.tag_we) || (|wr.data_we);

    always_comb begin
        if (wr_any) begin
            arr_idx = wr.index;
        end else begin
            case (rd_sel)
                NEW:         arr_idx = req.index;
                HELD_LOOKUP: arr_idx = look_req.index;
                default:     arr_idx = held_hit_idx;
            endcase
        end
    end

    for (genvar w = 0; w < `ICACHE_WAYS; w++) begin : g_way
        way_ram #(.entry_t(tag_entry_t)) u_tag_ram (
            .clk   (clk),
            .we    (wr.tag_we[w]),
            .addr  (arr_idx),
            .wdata (wr.entry),
            .rdata (tags[w])
        );

        way_ram #(.entry_t(line_t)) u_data_ram (
            .clk   (clk),
            .we    (wr.data_we[w]),
            .addr  (arr_idx),
            .wdata (wr.line),
            .rdata (lines[w])
        );
    end

endmodule

// ==== plru_victim.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module plru_victim (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        miss,
    input  icache_types_pkg::set_idx_t  set,
    input  logic                        update,
    output icache_types_pkg::way_mask_t victim
);

    import icache_types_pkg::*;

    logic [2:0] tree [`ICACHE_SETS];
    logic [2:0] cur;
    way_mask_t  pick;

    assign cur = tree[set];

    // bit0 picks the pair, bit1 or bit2 the way inside it
    always_comb begin
        if (!cur[0]) begin
            pick = cur[1] ? 4'b0010 : 4'b0001;
        end else begin
            pick = cur[2] ? 4'b1000 : 4'b0100;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst) begin
            for (int i = 0; i < `ICACHE_SETS; i++) begin
                tree[i] <= 3'b000;
            end
            victim <= '0;
        end else begin
            if (miss) begin
                victim <= pick;
            end
            if (update) begin
                case (victim)
                    4'b0001: tree[set] <= {cur[2], 1'b1, 1'b1};
                    4'b0010: tree[set] <= {cur[2], 1'b0, 1'b1};
                    4'b0100: tree[set] <= {1'b1, cur[1], 1'b0};
                    4'b1000: tree[set] <= {1'b0, cur[1], 1'b0};
                    default: tree[set] <= cur;
                endcase
            end
        end
    end

endmodule

// ==== way_ram.sv ====
`timescale 1ns/1ps
`include "icache_params.svh"

module way_ram #(
    parameter type entry_t = logic [31:0]
) (
    input  logic                       clk,
    input  logic                       we,
    input  icache_types_pkg::set_idx_t addr,
    input  entry_t                     wdata,
    output entry_t                     rdata
);

    entry_t mem [`ICACHE_SETS];

    // single address, write and registered read share it
    always_ff @(posedge clk) begin
        if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];
    end

endmodule

// ==== icache_mem_pkg.sv ====
package icache_mem_pkg;

    typedef struct packed {
        logic        valid;
        logic [31:0] addr;
    } mem_rd_req_t;

    typedef struct packed {
        logic        valid;
        logic [31:0] data;
        logic        last;
    } mem_rd_resp_t;

    // tag and data array write, sweep or line install
    typedef struct packed {
        icache_types_pkg::way_mask_t  tag_we;
        icache_types_pkg::way_mask_t  data_we;
        icache_types_pkg::set_idx_t   index;
        icache_types_pkg::tag_entry_t entry;
        icache_types_pkg::line_t      line;
    } array_wr_t;

    typedef struct packed {
        icache_types_pkg::set_idx_t index;
        icache_types_pkg::tag_t     tag;
        logic [1:0]                 half_done;
        icache_types_pkg::line_t    line;
    } fill_view_t;

endpackage

// ==== icache_types_pkg.sv ====
`include "icache_params.svh"

package icache_types_pkg;

    typedef logic [$clog2(`ICACHE_SETS)-1:0]  set_idx_t;
    typedef logic [`ICACHE_TAG_W-1:0]         tag_t;
    typedef logic                             half_t;
    typedef logic [`ICACHE_WAYS-1:0]          way_mask_t;
    typedef logic [`ICACHE_LINE_WORDS*32-1:0] line_t;
    typedef logic [`ICACHE_LINE_WORDS*16-1:0] half_line_t;

    typedef struct packed {
        logic valid;
        tag_t tag;
    } tag_entry_t;

    // one cpu fetch, tag and index together
    typedef struct packed {
        tag_t     tag;
        set_idx_t index;
        half_t    half;
    } cpu_req_t;

    typedef enum logic [2:0] {
        SWEEP, SETTLE, RUN, MISS, REFILL, FINISH, RECOVER
    } cache_state_t;

    typedef enum logic [1:0] {
        NEW, HELD_LOOKUP, HELD_HIT
    } rd_sel_t;

endpackage

// ==== icache_params.svh ====
`ifndef ICACHE_PARAMS_SVH
`define ICACHE_PARAMS_SVH

// cache geometry
`define ICACHE_WAYS 4
`define ICACHE_SETS 128

// eight 32-bit words per line
`define ICACHE_LINE_WORDS 8

// address bits above index and line offset
`define ICACHE_TAG_W 20

// one set invalidated per cycle after reset
`define ICACHE_SWEEP_CYCLES 128

`endif
